/* Bender.yml */
package:
  name: mem_subsys

sources:
  # Design, in compile order
  - hdl/rv_mem_pkg.sv
  - hdl/data_port_if.sv
  - hdl/mem_access_stage.sv
  - hdl/data_ram.sv
  - hdl/load_writeback.sv
  - hdl/mem_subsys_top.sv

  # Testbench
  - target: test
    files:
      - bench/mem_subsys_tb.sv

/* bench/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    // Expected writeback and the cycle count it is due at
    typedef struct packed {
        int                                    due;
        logic                                  exc;
        logic                                  wr_en;
        logic                                  data_ok;
        logic [rv_mem_pkg::REG_ADDR_W-1:0]     rd;
        logic [rv_mem_pkg::XLEN-1:0]           data;
    } wb_exp_t;

    logic                                  Clk;
    logic                                  arst_n_i;
    logic                                  ex_valid_i;
    rv_mem_pkg::mem_op_e                   ex_mem_op_i;
    logic [rv_mem_pkg::XLEN-1:0]           ex_alu_result_i;
    logic [rv_mem_pkg::XLEN-1:0]           ex_rs2_data_i;
    logic                                  ex_mem_to_reg_i;
    logic                                  ex_rd_wr_en_i;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]     ex_rd_addr_i;
    logic                                  ex_exception_i;
    logic                                  forward_m_i;
    logic                                  wb_valid_o;
    logic                                  wb_rd_wr_en_o;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]     wb_rd_addr_o;
    logic [rv_mem_pkg::XLEN-1:0]           wb_rd_data_o;
    logic                                  wb_exception_o;

    // Model state of 16 words of byte memory, last ALU result and expected queue
    logic [7:0]                    mem_model [64];
    logic [rv_mem_pkg::XLEN-1:0]   last_alu = '0;
    wb_exp_t                       exp_q[$];
    string                         name_q[$];
    logic [31:0]                   rng_state = 32'h7b4b;
    int                            cyc = 0;
    int                            err_cnt = 0;
    int                            chk_cnt = 0;
    wb_exp_t                       mon_rec;
    string                         mon_name;

    mem_subsys_top #(
        .RAM_ADDR_W (10)
    ) DUT (
        .Clk             (Clk),
        .arst_n_i        (arst_n_i),
        .ex_valid_i      (ex_valid_i),
        .ex_mem_op_i     (ex_mem_op_i),
        .ex_alu_result_i (ex_alu_result_i),
        .ex_rs2_data_i   (ex_rs2_data_i),
        .ex_mem_to_reg_i (ex_mem_to_reg_i),
        .ex_rd_wr_en_i   (ex_rd_wr_en_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_exception_i  (ex_exception_i),
        .forward_m_i     (forward_m_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_wr_en_o   (wb_rd_wr_en_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_rd_data_o    (wb_rd_data_o),
        .wb_exception_o  (wb_exception_o)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #50 Clk = ~Clk;
        end
    end

    // Edge counter read before its update at posedge
    always @(posedge Clk) begin
        cyc <= cyc + 1;
    end

    // ******************************
    // Random numbers and op helpers
    // ******************************

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rv_mem_pkg::mem_op_e pick_store(input logic [1:0] r);
        case (r)
            2'd0:    return rv_mem_pkg::MEM_SB;
            2'd1:    return rv_mem_pkg::MEM_SH;
            default: return rv_mem_pkg::MEM_SW;
        endcase
    endfunction

    function automatic rv_mem_pkg::mem_op_e pick_load(input logic [2:0] r);
        case (r)
            3'd0, 3'd5: return rv_mem_pkg::MEM_LB;
            3'd1, 3'd6: return rv_mem_pkg::MEM_LBU;
            3'd2, 3'd7: return rv_mem_pkg::MEM_LH;
            3'd3:       return rv_mem_pkg::MEM_LHU;
            default:    return rv_mem_pkg::MEM_LW;
        endcase
    endfunction

    function automatic logic loads_memory(input rv_mem_pkg::mem_op_e op);
        return op inside {rv_mem_pkg::MEM_LB, rv_mem_pkg::MEM_LBU, rv_mem_pkg::MEM_LH,
                          rv_mem_pkg::MEM_LHU, rv_mem_pkg::MEM_LW};
    endfunction

    function automatic logic stores_memory(input rv_mem_pkg::mem_op_e op);
        return op inside {rv_mem_pkg::MEM_SB, rv_mem_pkg::MEM_SH, rv_mem_pkg::MEM_SW};
    endfunction

    // Halfword on odd offset or word on nonzero offset
    function automatic logic expect_fault(input rv_mem_pkg::mem_op_e op, input logic [1:0] off);
        if (op inside {rv_mem_pkg::MEM_LH, rv_mem_pkg::MEM_LHU, rv_mem_pkg::MEM_SH}) begin
            return off[0];
        end
        if (op inside {rv_mem_pkg::MEM_LW, rv_mem_pkg::MEM_SW}) begin
            return off != 2'b00;
        end
        return 1'b0;
    endfunction

    function automatic logic [1:0] aligned_off(input rv_mem_pkg::mem_op_e op,
                                               input logic [1:0] r);
        if (op inside {rv_mem_pkg::MEM_LH, rv_mem_pkg::MEM_LHU, rv_mem_pkg::MEM_SH}) begin
            return {r[1], 1'b0};
        end
        if (op inside {rv_mem_pkg::MEM_LW, rv_mem_pkg::MEM_SW}) begin
            return 2'b00;
        end
        return r;
    endfunction

    // Byte address inside the small test window
    function automatic logic [31:0] word_addr(input logic [3:0] w, input logic [1:0] off);
        return {26'd0, w, off};
    endfunction

    // ******************************
    // Memory model
    // ******************************

    // Little endian with lane 0 at the lowest byte address
    function automatic logic [31:0] load_value(input rv_mem_pkg::mem_op_e op,
                                               input logic [5:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_model[a];
        h = {mem_model[(a + 1) % 64], mem_model[a]};
        case (op)
            rv_mem_pkg::MEM_LB:  return {{24{b[7]}}, b};
            rv_mem_pkg::MEM_LBU: return {24'd0, b};
            rv_mem_pkg::MEM_LH:  return {{16{h[15]}}, h};
            rv_mem_pkg::MEM_LHU: return {16'd0, h};
            default: return {mem_model[(a + 3) % 64], mem_model[(a + 2) % 64], h};
        endcase
    endfunction

    task automatic store_bytes(input rv_mem_pkg::mem_op_e op, input logic [5:0] a,
                               input logic [31:0] src);
        mem_model[a] = src[7:0];
        if (op != rv_mem_pkg::MEM_SB) begin
            mem_model[a + 1] = src[15:8];
        end
        if (op == rv_mem_pkg::MEM_SW) begin
            mem_model[a + 2] = src[23:16];
            mem_model[a + 3] = src[31:24];
        end
    endtask

    // ******************************
    // Compare tasks
    // ******************************

    task automatic check_data(input string name, input logic [rv_mem_pkg::XLEN-1:0] exp,
                              input logic [rv_mem_pkg::XLEN-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [rv_mem_pkg::REG_ADDR_W-1:0] exp,
                              input logic [rv_mem_pkg::REG_ADDR_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ******************************
    // Stimulus
    // ******************************

    // One strobe; model updated in program order
    task automatic issue(input string name, input rv_mem_pkg::mem_op_e op,
                         input logic [31:0] alu, input logic [31:0] rs2,
                         input logic rd_wr_en, input logic [4:0] rd,
                         input logic exc, input logic fwd);
        logic [31:0] src;
        logic        fault;
        wb_exp_t     rec;
        @(posedge Clk);
        ex_valid_i      <= 1'b1;
        ex_mem_op_i     <= op;
        ex_alu_result_i <= alu;
        ex_rs2_data_i   <= rs2;
        ex_mem_to_reg_i <= loads_memory(op);
        ex_rd_wr_en_i   <= rd_wr_en;
        ex_rd_addr_i    <= rd;
        ex_exception_i  <= exc;
        forward_m_i     <= fwd;
        fault     = expect_fault(op, alu[1:0]);
        src       = fwd ? last_alu : rs2;
        // Sampled next edge and registered by writeback one edge later
        rec.due   = cyc + 3;
        rec.exc   = exc | fault;
        rec.wr_en = rd_wr_en & ~rec.exc;
        rec.rd    = rd;
        rec.data  = loads_memory(op) ? load_value(op, alu[5:0]) : alu;
        // Misaligned load fetches no word
        rec.data_ok = !(loads_memory(op) && fault);
        if (stores_memory(op) && !fault) begin
            store_bytes(op, alu[5:0], src);
        end
        last_alu = alu;
        exp_q.push_back(rec);
        name_q.push_back(name);
    endtask

    task automatic idle();
        @(posedge Clk);
        ex_valid_i  <= 1'b0;
        forward_m_i <= 1'b0;
    endtask

    // ******************************
    // Writeback monitor
    // ******************************

    // Each writeback retires the oldest expected record
    always @(negedge Clk) begin
        if (arst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Writeback at cycle %0d with no instruction outstanding", cyc);
            end else begin
                mon_rec  = exp_q.pop_front();
                mon_name = name_q.pop_front();
                chk_cnt++;
                if (cyc != mon_rec.due) begin
                    err_cnt++;
                    $display("%s writeback arrived at cycle %0d, due at cycle %0d",
                             mon_name, cyc, mon_rec.due);
                end
                check_flag({mon_name, " wr_en"}, mon_rec.wr_en, wb_rd_wr_en_o);
                check_flag({mon_name, " exception"}, mon_rec.exc, wb_exception_o);
                check_addr({mon_name, " rd"}, mon_rec.rd, wb_rd_addr_o);
                if (mon_rec.data_ok) begin
                    check_data({mon_name, " data"}, mon_rec.data, wb_rd_data_o);
                end
            end
        end
    end

    initial begin
        logic [31:0]         r;
        logic [31:0]         v;
        rv_mem_pkg::mem_op_e op;
        int                  wait_cnt;
        arst_n_i        = 1'b0;
        ex_valid_i      = 1'b0;
        ex_mem_op_i     = rv_mem_pkg::MEM_NONE;
        ex_alu_result_i = '0;
        ex_rs2_data_i   = '0;
        ex_mem_to_reg_i = 1'b0;
        ex_rd_wr_en_i   = 1'b0;
        ex_rd_addr_i    = '0;
        ex_exception_i  = 1'b0;
        forward_m_i     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = 8'h00;
        end
        repeat (4) @(posedge Clk);
        arst_n_i <= 1'b1;
        @(negedge Clk);
        check_flag("reset valid", 1'b0, wb_valid_o);
        check_flag("reset wr_en", 1'b0, wb_rd_wr_en_o);
        check_flag("reset exception", 1'b0, wb_exception_o);

        // Aligned stores then loads with random gaps
        for (int i = 0; i < 40; i++) begin
            r  = next_rand();
            v  = next_rand();
            op = pick_store(r[1:0]);
            issue("rt store", op, word_addr(r[5:2], aligned_off(op, r[7:6])), v, 1'b0,
                  r[12:8], 1'b0, 1'b0);
            if (r[31]) begin
                idle();
            end
        end
        for (int i = 0; i < 40; i++) begin
            r  = next_rand();
            op = pick_load(r[2:0]);
            issue("rt load", op, word_addr(r[6:3], aligned_off(op, r[8:7])), 32'h0, 1'b1,
                  r[13:9], 1'b0, 1'b0);
            if (r[31]) begin
                idle();
            end
        end
        idle();

        // Load right behind a store to the same word
        for (int i = 0; i < 30; i++) begin
            r  = next_rand();
            v  = next_rand();
            op = pick_store(r[1:0]);
            issue("b2b store", op, word_addr(r[5:2], aligned_off(op, r[7:6])), v, 1'b0,
                  r[12:8], 1'b0, 1'b0);
            op = pick_load(r[15:13]);
            issue("b2b load", op, word_addr(r[5:2], aligned_off(op, r[17:16])), 32'h0, 1'b1,
                  r[22:18], 1'b0, 1'b0);
        end
        idle();

        // Store data forwarded from the previous ALU result
        for (int i = 0; i < 8; i++) begin
            r  = next_rand();
            v  = next_rand();
            op = pick_store(r[1:0]);
            issue("fwd alu", rv_mem_pkg::MEM_NONE, v, 32'h0, 1'b1, r[12:8], 1'b0, 1'b0);
            issue("fwd store", op, word_addr(r[5:2], aligned_off(op, r[7:6])), ~v, 1'b0,
                  5'd0, 1'b0, 1'b1);
            issue("fwd load", rv_mem_pkg::MEM_LW, word_addr(r[5:2], 2'b00), 32'h0, 1'b1,
                  r[17:13], 1'b0, 1'b0);
        end
        idle();

        // Misaligned stores and loads plus incoming exception
        for (int i = 0; i < 10; i++) begin
            r  = next_rand();
            v  = next_rand();
            op = r[0] ? rv_mem_pkg::MEM_SH : rv_mem_pkg::MEM_SW;
            issue("mis store", op, word_addr(r[5:2], (!r[0] && r[6]) ? 2'd2 : {r[7], 1'b1}),
                  v, 1'b1, r[12:8], 1'b0, 1'b0);
            issue("mis check", rv_mem_pkg::MEM_LW, word_addr(r[5:2], 2'b00), 32'h0, 1'b1,
                  r[17:13], 1'b0, 1'b0);
            op = r[18] ? rv_mem_pkg::MEM_LW : (r[19] ? rv_mem_pkg::MEM_LH : rv_mem_pkg::MEM_LHU);
            issue("mis load", op, word_addr(r[23:20], {r[24], 1'b1}), 32'h0, 1'b1,
                  r[29:25], 1'b0, 1'b0);
            issue("exc load", rv_mem_pkg::MEM_LW, word_addr(r[5:2], 2'b00), 32'h0, 1'b1,
                  r[12:8], 1'b1, 1'b0);
            issue("exc alu", rv_mem_pkg::MEM_NONE, v, 32'h0, 1'b1, r[17:13], 1'b1, 1'b0);
        end
        idle();

        // Plain ALU results passing through
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            v = next_rand();
            issue("alu", rv_mem_pkg::MEM_NONE, v, next_rand(), r[0], r[5:1], 1'b0, 1'b0);
        end
        idle();

        // Drain outstanding writebacks
        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 20) begin
            @(posedge Clk);
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            err_cnt++;
            $display("Timeout: %0d writebacks never arrived", exp_q.size());
        end
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/data_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface data_port_if #(
    parameter int RAM_ADDR_W = 10
) ();

    // Word address, low byte bits stripped
    logic [RAM_ADDR_W-1:0]         addr;
    logic [rv_mem_pkg::XLEN-1:0]   wr_data;
    // One enable per byte lane
    logic [3:0]                    be;
    logic                          rd_en;
    // Registered read word
    logic [rv_mem_pkg::XLEN-1:0]   rd_data;

    // Access stage side
    modport requester (
        output addr,
        output wr_data,
        output be,
        output rd_en
    );

    // RAM side
    modport responder (
        input  addr,
        input  wr_data,
        input  be,
        input  rd_en,
        output rd_data
    );

    // Writeback only looks at the read word
    modport monitor (
        input  rd_data
    );

endinterface

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_ADDR_W = 10
) (
    input  wire logic        Clk,
    data_port_if.responder   mem_port
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;
    // Byte lanes per word
    localparam int LANES = rv_mem_pkg::XLEN / 8;

    logic [rv_mem_pkg::XLEN-1:0] ram_q [DEPTH];

    // Unwritten words read back as zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram_q[i] = '0;
        end
    end

    // ******************************
    // Byte-enabled write
    // ******************************

    always_ff @(posedge Clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (mem_port.be[lane]) begin
                ram_q[mem_port.addr][8*lane +: 8] <= mem_port.wr_data[8*lane +: 8];
            end
        end
    end

    // ******************************
    // Registered read
    // ******************************

    // Old contents returned on a same-edge write
    always_ff @(posedge Clk) begin
        if (mem_port.rd_en) begin
            mem_port.rd_data <= ram_q[mem_port.addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/load_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module load_writeback (
    input  wire logic                                  Clk,
    input  wire logic                                  arst_n_i,
    input  wire rv_mem_pkg::mem_ctrl_t                 ctrl_i,
    data_port_if.monitor                               mem_port,
    output logic                                       wb_valid_o,
    output logic                                       wb_rd_wr_en_o,
    output logic [rv_mem_pkg::REG_ADDR_W-1:0]          wb_rd_addr_o,
    output logic [rv_mem_pkg::XLEN-1:0]                wb_rd_data_o,
    output logic                                       wb_exception_o
);

    localparam int XLEN = rv_mem_pkg::XLEN;

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_data;
    logic [XLEN-1:0] wb_data;

    // ******************************
    // Lane extraction
    // ******************************

    always_comb begin
        // Byte at the staged offset
        ld_byte = mem_port.rd_data[{ctrl_i.byte_off, 3'b000} +: 8];
        // Upper or lower half by offset bit 1
        ld_half = ctrl_i.byte_off[1] ? mem_port.rd_data[XLEN-1:16]
                                     : mem_port.rd_data[15:0];
    end

    // Sign or zero extension per op
    always_comb begin
        case (ctrl_i.op)
            rv_mem_pkg::MEM_LB:  ld_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            rv_mem_pkg::MEM_LBU: ld_data = {{(XLEN-8){1'b0}}, ld_byte};
            rv_mem_pkg::MEM_LH:  ld_data = {{(XLEN-16){ld_half[15]}}, ld_half};
            rv_mem_pkg::MEM_LHU: ld_data = {{(XLEN-16){1'b0}}, ld_half};
            rv_mem_pkg::MEM_LW:  ld_data = mem_port.rd_data;
            default:             ld_data = '0;
        endcase
    end

    // Memory value or ALU result
    always_comb begin
        wb_data = ctrl_i.mem_to_reg ? ld_data : ctrl_i.alu_result;
    end

    // ******************************
    // Writeback register
    // ******************************

    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o     <= 1'b0;
            wb_rd_wr_en_o  <= 1'b0;
            wb_exception_o <= 1'b0;
        end else begin
            wb_valid_o     <= ctrl_i.valid;
            // No register write on a faulting instruction
            wb_rd_wr_en_o  <= ctrl_i.valid & ctrl_i.rd_wr_en & ~ctrl_i.exception;
            wb_exception_o <= ctrl_i.valid & ctrl_i.exception;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge Clk) begin
        wb_rd_addr_o <= ctrl_i.rd_addr;
        wb_rd_data_o <= wb_data;
    end

endmodule

`default_nettype wire

/* hdl/mem_access_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage (
    input  wire logic                                  Clk,
    input  wire logic                                  arst_n_i,
    input  wire logic                                  ex_valid_i,
    input  wire rv_mem_pkg::mem_op_e                   ex_mem_op_i,
    input  wire logic [rv_mem_pkg::XLEN-1:0]           ex_alu_result_i,
    input  wire logic [rv_mem_pkg::XLEN-1:0]           ex_rs2_data_i,
    input  wire logic                                  ex_mem_to_reg_i,
    input  wire logic                                  ex_rd_wr_en_i,
    input  wire logic [rv_mem_pkg::REG_ADDR_W-1:0]     ex_rd_addr_i,
    input  wire logic                                  ex_exception_i,
    input  wire logic                                  forward_m_i,
    data_port_if.requester                             mem_port,
    output rv_mem_pkg::mem_ctrl_t                      ctrl_o
);

    // Word address width follows the RAM port
    localparam int ADDR_W = $bits(mem_port.addr);

    logic [1:0]                          offset;
    logic                                misaligned;
    logic [rv_mem_pkg::XLEN-1:0]         st_src;
    logic [rv_mem_pkg::XLEN-1:0]         st_data;
    logic [3:0]                          st_be;

    // Staged control, cleared by reset
    logic                                valid_q;
    logic                                rd_wr_en_q;
    logic                                exception_q;

    // Staged payload, loaded on accepted instructions only
    rv_mem_pkg::mem_op_e                 op_q;
    logic [1:0]                          offset_q;
    logic                                mem_to_reg_q;
    logic [rv_mem_pkg::XLEN-1:0]         alu_q;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]   rd_addr_q;

    // ******************************
    // Alignment and store source
    // ******************************

    always_comb begin
        offset     = ex_alu_result_i[1:0];
        misaligned = ex_valid_i & rv_mem_pkg::is_misaligned(ex_mem_op_i, offset);
        // Forward previous ALU result over the register operand
        st_src     = forward_m_i ? alu_q : ex_rs2_data_i;
    end

    // ******************************
    // Store lane placement
    // ******************************

    // Data replicated into every lane, byte enables pick the lane
    always_comb begin
        case (ex_mem_op_i)
            rv_mem_pkg::MEM_SB: begin
                st_data = {4{st_src[7:0]}};
                st_be   = 4'b0001 << offset;
            end
            rv_mem_pkg::MEM_SH: begin
                st_data = {2{st_src[15:0]}};
                st_be   = offset[1] ? 4'b1100 : 4'b0011;
            end
            rv_mem_pkg::MEM_SW: begin
                st_data = st_src;
                st_be   = 4'b1111;
            end
            default: begin
                // Loads and non-memory ops write nothing
                st_data = st_src;
                st_be   = 4'b0000;
            end
        endcase
    end

    // RAM request, combinational from the EX inputs
    always_comb begin
        mem_port.addr    = ex_alu_result_i[2 +: ADDR_W];
        mem_port.wr_data = st_data;
        // Misaligned store is suppressed entirely
        mem_port.be      = (ex_valid_i && !misaligned) ? st_be : 4'b0000;
        mem_port.rd_en   = ex_valid_i & rv_mem_pkg::is_load(ex_mem_op_i) & ~misaligned;
    end

    // ******************************
    // Stage register
    // ******************************

    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q     <= 1'b0;
            rd_wr_en_q  <= 1'b0;
            exception_q <= 1'b0;
        end else begin
            valid_q     <= ex_valid_i;
            rd_wr_en_q  <= ex_valid_i & ex_rd_wr_en_i;
            // Incoming exception merged with alignment fault
            exception_q <= ex_valid_i & (ex_exception_i | misaligned);
        end
    end

    // Holds last accepted instruction, also the forwarding source
    always_ff @(posedge Clk) begin
        if (ex_valid_i) begin
            op_q         <= ex_mem_op_i;
            offset_q     <= offset;
            mem_to_reg_q <= ex_mem_to_reg_i;
            alu_q        <= ex_alu_result_i;
            rd_addr_q    <= ex_rd_addr_i;
        end
    end

    // Pack for writeback
    always_comb begin
        ctrl_o.valid      = valid_q;
        ctrl_o.op         = op_q;
        ctrl_o.byte_off   = offset_q;
        ctrl_o.mem_to_reg = mem_to_reg_q;
        ctrl_o.alu_result = alu_q;
        ctrl_o.rd_addr    = rd_addr_q;
        ctrl_o.rd_wr_en   = rd_wr_en_q;
        ctrl_o.exception  = exception_q;
    end

endmodule

`default_nettype wire

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    // Word address width of the data RAM
    parameter int RAM_ADDR_W = 10
) (
    input  wire logic                                  Clk,
    input  wire logic                                  arst_n_i,

    // Execute stage side
    input  wire logic                                  ex_valid_i,
    input  wire rv_mem_pkg::mem_op_e                   ex_mem_op_i,
    input  wire logic [rv_mem_pkg::XLEN-1:0]           ex_alu_result_i,
    input  wire logic [rv_mem_pkg::XLEN-1:0]           ex_rs2_data_i,
    input  wire logic                                  ex_mem_to_reg_i,
    input  wire logic                                  ex_rd_wr_en_i,
    input  wire logic [rv_mem_pkg::REG_ADDR_W-1:0]     ex_rd_addr_i,
    input  wire logic                                  ex_exception_i,
    // Store data taken from the previous ALU result
    input  wire logic                                  forward_m_i,

    // Register file write
    output logic                                       wb_valid_o,
    output logic                                       wb_rd_wr_en_o,
    output logic [rv_mem_pkg::REG_ADDR_W-1:0]          wb_rd_addr_o,
    output logic [rv_mem_pkg::XLEN-1:0]                wb_rd_data_o,
    output logic                                       wb_exception_o
);

    // Staged instruction into writeback
    rv_mem_pkg::mem_ctrl_t stage_ctrl;

    // ******************************
    // Data RAM port
    // ******************************

    data_port_if #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) mem_port ();

    // ******************************
    // Pipeline blocks
    // ******************************

    mem_access_stage u_access (
        .Clk             (Clk),
        .arst_n_i        (arst_n_i),
        .ex_valid_i      (ex_valid_i),
        .ex_mem_op_i     (ex_mem_op_i),
        .ex_alu_result_i (ex_alu_result_i),
        .ex_rs2_data_i   (ex_rs2_data_i),
        .ex_mem_to_reg_i (ex_mem_to_reg_i),
        .ex_rd_wr_en_i   (ex_rd_wr_en_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_exception_i  (ex_exception_i),
        .forward_m_i     (forward_m_i),
        .mem_port        (mem_port),
        .ctrl_o          (stage_ctrl)
    );

    data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .Clk      (Clk),
        .mem_port (mem_port)
    );

    load_writeback u_wb (
        .Clk            (Clk),
        .arst_n_i       (arst_n_i),
        .ctrl_i         (stage_ctrl),
        .mem_port       (mem_port),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_wr_en_o  (wb_rd_wr_en_o),
        .wb_rd_addr_o   (wb_rd_addr_o),
        .wb_rd_data_o   (wb_rd_data_o),
        .wb_exception_o (wb_exception_o)
    );

endmodule

`default_nettype wire

/* hdl/rv_mem_pkg.sv */
`default_nettype none

package rv_mem_pkg;

    // ******************************
    // Widths
    // ******************************

    // Data and byte address width
    localparam int XLEN = 32;
    // Register file index
    localparam int REG_ADDR_W = 5;

    // ******************************
    // Memory operation encoding
    // ******************************

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        // Loads
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        // Stores
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // One instruction held between access stage and writeback
    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [1:0]            byte_off;
        logic                  mem_to_reg;
        logic [XLEN-1:0]       alu_result;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_wr_en;
        logic                  exception;
    } mem_ctrl_t;

    // Any of the five load flavours
    function automatic logic is_load(input mem_op_e op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    // Halfword needs even offset, word needs offset zero
    function automatic logic is_misaligned(input mem_op_e op, input logic [1:0] off);
        logic half_op;
        logic word_op;
        half_op = op inside {MEM_LH, MEM_LHU, MEM_SH};
        word_op = op inside {MEM_LW, MEM_SW};
        return (half_op && off[0]) || (word_op && (off != 2'b00));
    endfunction

endpackage

`default_nettype wire

/* src.f */
hdl/rv_mem_pkg.sv
hdl/data_port_if.sv
hdl/mem_access_stage.sv
hdl/data_ram.sv
hdl/load_writeback.sv
hdl/mem_subsys_top.sv
bench/mem_subsys_tb.sv
